/* common/modred_pkg.sv */
package modred_pkg;

  // Datapath widths.
  localparam int unsigned DATA_LENGTH = 64;  // Product and fold word width.
  localparam int unsigned OPERAND_W   = 32;  // Width of a, b, c and d.
  localparam int unsigned SHIFT_W     = 6;   // Wide enough for k and s up to 63.

  // Reduction depth per lane.
  // Three folds bring a 46-bit Dilithium product below 2m.
  localparam int unsigned NUM_RED = 3;

  // Product register, NUM_RED fold registers and the lane subtract register
  // take five edges; the combiner register adds one more edge after that.
  localparam int unsigned PIPE_LATENCY = 5;

  // Product, fold value, modulus and mask.
  typedef logic [DATA_LENGTH-1:0] word_t;

  // Input operands.
  typedef logic [OPERAND_W-1:0] operand_t;

  // Exponents k and s of m = 2^k - 2^s + 1.
  typedef logic [SHIFT_W-1:0] shamt_t;

endpackage : modred_pkg

/* common/modred_cfg_if.sv */
`timescale 1ns/10ps

interface modred_cfg_if;
  import modred_pkg::*;

  // Derived modulus settings, held as levels between loads.
  word_t  modulus;     // m = 2^k - 2^s + 1.
  word_t  low_mask;    // 2^k - 1, selects the low part of a word.
  shamt_t mod_bits;    // k, shift that extracts the high part.
  shamt_t fold_shift;  // s, shift applied to the high part.

  // Config block side.
  modport cfg_src (
    output modulus,
    output low_mask,
    output mod_bits,
    output fold_shift
  );

  // Lanes and combiner.
  modport cfg_dst (
    input modulus,
    input low_mask,
    input mod_bits,
    input fold_shift
  );

endinterface : modred_cfg_if

/* verilog/modred_config.sv */
`timescale 1ns/10ps

module modred_config (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                cfg_load_i,
  input  modred_pkg::shamt_t  mod_bits_i,
  input  modred_pkg::shamt_t  fold_shift_i,
  modred_cfg_if.cfg_src       cfg
);
  import modred_pkg::*;

  word_t pow_k;  // 2^k from the incoming k.
  word_t pow_s;  // 2^s from the incoming s.
  word_t modulus_d;
  word_t low_mask_d;

  // The wide arithmetic sits in front of the load registers only.
  always_comb begin
    pow_k      = word_t'(1) << mod_bits_i;
    pow_s      = word_t'(1) << fold_shift_i;
    modulus_d  = pow_k - pow_s + word_t'(1);  // m = 2^k - 2^s + 1.
    low_mask_d = pow_k - word_t'(1);          // Ones in bits k-1..0.
  end

  // Load on the strobe, keep otherwise.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg.mod_bits   <= '0;
      cfg.fold_shift <= '0;
      cfg.modulus    <= '0;
      cfg.low_mask   <= '0;
    end else if (cfg_load_i) begin
      cfg.mod_bits   <= mod_bits_i;
      cfg.fold_shift <= fold_shift_i;
      cfg.modulus    <= modulus_d;
      cfg.low_mask   <= low_mask_d;
    end
  end

endmodule : modred_config

/* fold_lane/fold_stage.sv */
`timescale 1ns/10ps

module fold_stage (
  input  modred_pkg::word_t  x_i,
  modred_cfg_if.cfg_dst      cfg,
  output modred_pkg::word_t  result_o
);
  import modred_pkg::*;

  word_t lo_part;
  word_t hi_part;
  word_t hi_scaled;

  // With 2^k = 2^s - 1 (mod m), hi*2^k folds to hi*2^s - hi.
  always_comb begin
    lo_part   = x_i & cfg.low_mask;        // Bits below k.
    hi_part   = x_i >> cfg.mod_bits;       // Bits from k upward.
    hi_scaled = hi_part << cfg.fold_shift; // Always >= hi_part, no underflow.
    result_o  = lo_part + hi_scaled - hi_part;
  end

endmodule : fold_stage

/* fold_lane/fold_lane.sv */
`timescale 1ns/10ps

module fold_lane (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  modred_pkg::operand_t op_x_i,
  input  modred_pkg::operand_t op_y_i,
  modred_cfg_if.cfg_dst        cfg,
  output modred_pkg::word_t    result_o
);
  import modred_pkg::*;

  word_t prod_q;                // Full 64-bit product.
  word_t stage_in  [NUM_RED];
  word_t stage_out [NUM_RED];
  word_t fold_q    [NUM_RED];   // One register behind every fold.
  word_t last_fold;
  word_t reduced;

  // Edge 0: product of the sampled operands.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prod_q <= '0;
    end else begin
      prod_q <= word_t'(op_x_i) * word_t'(op_y_i);
    end
  end

  // Edges 1 to NUM_RED: one fold each.
  for (genvar i = 0; i < NUM_RED; i++) begin : g_fold
    if (i == 0) begin : g_first
      assign stage_in[i] = prod_q;
    end else begin : g_next
      assign stage_in[i] = fold_q[i-1];
    end

    fold_stage u_fold_stage (
      .x_i      (stage_in[i]),
      .cfg      (cfg),
      .result_o (stage_out[i])
    );

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        fold_q[i] <= '0;
      end else begin
        fold_q[i] <= stage_out[i];
      end
    end
  end

  // After the last fold the value is below 2m, so one subtract is enough.
  assign last_fold = fold_q[NUM_RED-1];
  assign reduced   = (last_fold >= cfg.modulus) ? last_fold - cfg.modulus : last_fold;

  // Edge NUM_RED + 1: lane result below m.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      result_o <= '0;
    end else begin
      result_o <= reduced;
    end
  end

endmodule : fold_lane

/* verilog/mod_combine.sv */
`timescale 1ns/10ps

module mod_combine (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               start_i,
  input  modred_pkg::word_t  lane_a_i,
  input  modred_pkg::word_t  lane_b_i,
  modred_cfg_if.cfg_dst      cfg,
  output modred_pkg::word_t  result_o,
  output logic               valid_o
);
  import modred_pkg::*;

  logic [PIPE_LATENCY-1:0] start_q;  // start_i delayed to match the lanes.
  logic                    lane_valid;
  word_t                   sum;
  word_t                   sum_red;

  // Both inputs are below m, so the sum is below 2m.
  assign sum        = lane_a_i + lane_b_i;
  assign sum_red    = (sum >= cfg.modulus) ? sum - cfg.modulus : sum;
  assign lane_valid = start_q[PIPE_LATENCY-1];  // Lane outputs belong to a start.

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      start_q <= '0;
      valid_o <= 1'b0;
    end else begin
      start_q <= {start_q[PIPE_LATENCY-2:0], start_i};
      valid_o <= lane_valid;
    end
  end

  // Capture only sums that come from a real item.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      result_o <= '0;
    end else if (lane_valid) begin
      result_o <= sum_red;
    end
  end

endmodule : mod_combine

/* verilog/dot_mod_top.sv */
`timescale 1ns/10ps

module dot_mod_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 cfg_load_i,
  input  modred_pkg::shamt_t   mod_bits_i,    // k of m = 2^k - 2^s + 1.
  input  modred_pkg::shamt_t   fold_shift_i,  // s of m = 2^k - 2^s + 1.
  input  logic                 start_i,
  input  modred_pkg::operand_t a_i,
  input  modred_pkg::operand_t b_i,
  input  modred_pkg::operand_t c_i,
  input  modred_pkg::operand_t d_i,
  output modred_pkg::word_t    result_o,      // (a*b + c*d) mod m.
  output logic                 valid_o
);
  import modred_pkg::*;

  word_t lane_ab;  // a*b mod m.
  word_t lane_cd;  // c*d mod m.

  modred_cfg_if cfg_if ();

  modred_config u_config (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cfg_load_i   (cfg_load_i),
    .mod_bits_i   (mod_bits_i),
    .fold_shift_i (fold_shift_i),
    .cfg          (cfg_if.cfg_src)
  );

  fold_lane u_lane_ab (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .op_x_i   (a_i),
    .op_y_i   (b_i),
    .cfg      (cfg_if.cfg_dst),
    .result_o (lane_ab)
  );

  fold_lane u_lane_cd (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .op_x_i   (c_i),
    .op_y_i   (d_i),
    .cfg      (cfg_if.cfg_dst),
    .result_o (lane_cd)
  );

  // Final modular add and output strobe.
  mod_combine u_combine (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .start_i  (start_i),
    .lane_a_i (lane_ab),
    .lane_b_i (lane_cd),
    .cfg      (cfg_if.cfg_dst),
    .result_o (result_o),
    .valid_o  (valid_o)
  );

endmodule : dot_mod_top

/* testbench/tb_vectors.svh */
// One table entry per item, issued in order; a config load runs whenever k or s changes.
typedef struct packed {
  int unsigned k;         // Exponent k of m = 2^k - 2^s + 1.
  int unsigned s;         // Exponent s.
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] c;
  logic [31:0] d;
  logic [63:0] expected;  // (a*b + c*d) mod m.
} vec_t;

localparam int unsigned NUM_VEC = 20;

vec_t vec_table [NUM_VEC];

task automatic load_vectors();
  // Columns are k, s, a, b, c, d, expected result.
  // Dilithium prime 8380417 (k 23, s 13).
  vec_table[0]  = '{23, 13, 0, 0, 0, 0, 64'd0};
  vec_table[1]  = '{23, 13, 1, 1, 0, 0, 64'd1};
  vec_table[2]  = '{23, 13, 8380416, 1, 1, 1, 64'd0};               // Lane sum equals m.
  vec_table[3]  = '{23, 13, 8380416, 8380416, 0, 5, 64'd1};
  vec_table[4]  = '{23, 13, 8380416, 1, 8380416, 1, 64'd8380415};   // Lane sum above m.
  vec_table[5]  = '{23, 13, 8380416, 8380416, 8380416, 8380416, 64'd2};
  vec_table[6]  = '{23, 13, 8380416, 2, 3, 0, 64'd8380415};
  vec_table[7]  = '{23, 13, 4096, 4096, 0, 0, 64'd16382};
  vec_table[8]  = '{23, 13, 4194304, 4, 12345, 1, 64'd28727};
  vec_table[9]  = '{23, 13, 8380416, 8380415, 8380414, 3, 64'd8380410};
  vec_table[10] = '{23, 13, 8191, 1024, 0, 7, 64'd7167};
  vec_table[11] = '{23, 13, 3000000, 3, 4000000, 2, 64'd239166};
  // Prime 65521 (k 16, s 4).
  vec_table[12] = '{16, 4, 65520, 65520, 0, 0, 64'd1};
  vec_table[13] = '{16, 4, 65520, 1, 1, 1, 64'd0};
  vec_table[14] = '{16, 4, 65520, 1, 65520, 1, 64'd65519};
  vec_table[15] = '{16, 4, 256, 256, 2, 3, 64'd21};
  vec_table[16] = '{16, 4, 1000, 1000, 0, 0, 64'd17185};
  vec_table[17] = '{16, 4, 60000, 2, 50000, 1, 64'd38958};
  vec_table[18] = '{16, 4, 0, 65520, 65520, 0, 64'd0};
  vec_table[19] = '{16, 4, 12345, 1, 0, 0, 64'd12345};
endtask

/* testbench/tb_dot_mod.sv */
`timescale 1ns/10ps

module tb_dot_mod;
  import modred_pkg::*;

  localparam int unsigned CLK_PERIOD   = 100;
  localparam int unsigned DRIVE_DLY    = 1;    // Input skew after the rising edge.
  localparam int unsigned RESET_CYCLES = 16;
  localparam int unsigned IDLE_CHECKS  = 8;
  localparam int unsigned RAND_PER_MOD = 200;
  localparam int unsigned DIL_K        = 23;
  localparam int unsigned DIL_S        = 13;
  localparam int unsigned ALT_K        = 16;
  localparam int unsigned ALT_S        = 4;

  `include "tb_vectors.svh"

  // Random items may take two cycles each and every config load adds idle cycles.
  localparam int unsigned MAX_CYCLES = RESET_CYCLES + IDLE_CHECKS + NUM_VEC
                                     + 2 * 2 * RAND_PER_MOD
                                     + 4 * (PIPE_LATENCY + 3) + 100;

  logic     clk_i = 1'b0;
  logic     rst_ni;
  logic     cfg_load_i;
  shamt_t   mod_bits_i;
  shamt_t   fold_shift_i;
  logic     start_i;
  operand_t a_i;
  operand_t b_i;
  operand_t c_i;
  operand_t d_i;
  word_t    result_o;
  logic     valid_o;

  logic [31:0] lfsr_state = 32'hc62ea9af;
  int unsigned cycle_cnt  = 0;
  int unsigned items_seen = 0;
  logic [63:0] exp_q [$];   // Expected results in issue order.
  int unsigned edge_q [$];  // Edge that sampled each start_i.

  dot_mod_top u_dut (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cfg_load_i   (cfg_load_i),
    .mod_bits_i   (mod_bits_i),
    .fold_shift_i (fold_shift_i),
    .start_i      (start_i),
    .a_i          (a_i),
    .b_i          (b_i),
    .c_i          (c_i),
    .d_i          (d_i),
    .result_o     (result_o),
    .valid_o      (valid_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // Edge counter and run limit.
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
      $display("TESTS FAILED");
      $fatal(1, "Timeout.");
    end
  end

  task automatic check_value(input logic [63:0] got, input logic [63:0] expected,
                             input string what);
    if (got !== expected) begin
      $display("CHECK FAILED at %0t ns: %s got %0d expected %0d", $time, what, got, expected);
      $display("TESTS FAILED");
      $fatal(1, "Value mismatch.");
    end
  endtask

  // Fibonacci LFSR with taps 32 22 2 1 and one step per returned bit.
  function automatic logic [31:0] draw_bits(input int unsigned n);
    logic [31:0] value;
    logic        fb;
    int unsigned i;
    value = '0;
    for (i = 0; i < n; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      value      = {value[30:0], fb};
    end
    return value;
  endfunction

  function automatic logic [63:0] modulus_of(input int unsigned k, input int unsigned s);
    return (64'd1 << k) - (64'd1 << s) + 64'd1;
  endfunction

  // Reference model from the dot-product rule.
  function automatic logic [63:0] dot_mod_ref(input int unsigned k, input int unsigned s,
                                              input logic [31:0] a, input logic [31:0] b,
                                              input logic [31:0] c, input logic [31:0] d);
    logic [63:0] m;
    m = modulus_of(k, s);
    return (64'(a) * 64'(b) + 64'(c) * 64'(d)) % m;
  endfunction

  // Operand below m with m - 1 picked about one time in eight.
  function automatic logic [31:0] pick_operand(input int unsigned k, input logic [63:0] m);
    logic [31:0] value;
    if (draw_bits(3) == 32'd0) begin
      value = 32'(m - 64'd1);
    end else begin
      value = draw_bits(k);
      if (64'(value) >= m) value = value - 32'(m);
    end
    return value;
  endfunction

  task automatic next_cycle();
    @(posedge clk_i);
    #DRIVE_DLY;
  endtask

  task automatic issue_item(input logic [31:0] a, input logic [31:0] b,
                            input logic [31:0] c, input logic [31:0] d,
                            input logic [63:0] expected);
    start_i = 1'b1;
    a_i     = a;
    b_i     = b;
    c_i     = c;
    d_i     = d;
    exp_q.push_back(expected);
    edge_q.push_back(cycle_cnt + 1);  // Sampled at the coming edge.
  endtask

  // Drain the pipeline, pulse the load strobe and clear k and s again.
  task automatic load_config(input int unsigned k, input int unsigned s);
    repeat (PIPE_LATENCY + 1) begin
      next_cycle();
      start_i = 1'b0;
    end
    next_cycle();
    cfg_load_i   = 1'b1;
    mod_bits_i   = shamt_t'(k);
    fold_shift_i = shamt_t'(s);
    next_cycle();
    cfg_load_i   = 1'b0;
    mod_bits_i   = '0;  // Items must run on the latched values.
    fold_shift_i = '0;
  endtask

  // Result and latency check on every valid_o.
  always @(negedge clk_i) begin
    logic [63:0] expected;
    int unsigned start_edge;
    if (rst_ni && valid_o) begin
      if (exp_q.size() == 0) begin
        $display("valid_o went high at %0t ns with no item in flight", $time);
        $display("TESTS FAILED");
        $fatal(1, "Unexpected valid_o.");
      end else begin
        expected   = exp_q.pop_front();
        start_edge = edge_q.pop_front();
        check_value(result_o, expected, $sformatf("result_o of item %0d", items_seen));
        check_value(64'(cycle_cnt - start_edge), 64'(PIPE_LATENCY),
                    $sformatf("valid_o latency of item %0d", items_seen));
        items_seen = items_seen + 1;
      end
    end
  end

  initial begin
    int unsigned idx;
    int unsigned sel;
    int unsigned n;
    int unsigned k;
    int unsigned s;
    int unsigned cur_k;
    int unsigned cur_s;
    logic [63:0] m;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;

    rst_ni       = 1'b0;
    cfg_load_i   = 1'b0;
    mod_bits_i   = '0;
    fold_shift_i = '0;
    start_i      = 1'b0;
    a_i          = '0;
    b_i          = '0;
    c_i          = '0;
    d_i          = '0;
    cur_k        = 0;  // Config block resets to k = 0 and s = 0.
    cur_s        = 0;
    load_vectors();

    repeat (RESET_CYCLES) @(posedge clk_i);
    #DRIVE_DLY;
    rst_ni = 1'b1;

    // Quiet outputs before the first start.
    repeat (IDLE_CHECKS) begin
      @(negedge clk_i);
      check_value(64'(valid_o), 64'd0, "valid_o after reset");
      check_value(result_o, 64'd0, "result_o after reset");
    end

    // Table items go back to back while the modulus stays the same.
    for (idx = 0; idx < NUM_VEC; idx++) begin
      if (vec_table[idx].k != cur_k || vec_table[idx].s != cur_s) begin
        load_config(vec_table[idx].k, vec_table[idx].s);
        cur_k = vec_table[idx].k;
        cur_s = vec_table[idx].s;
      end
      next_cycle();
      issue_item(vec_table[idx].a, vec_table[idx].b, vec_table[idx].c, vec_table[idx].d,
                 vec_table[idx].expected);
    end

    // Random items under both moduli with occasional idle cycles.
    for (sel = 0; sel < 2; sel++) begin
      k = (sel == 0) ? DIL_K : ALT_K;
      s = (sel == 0) ? DIL_S : ALT_S;
      m = modulus_of(k, s);
      load_config(k, s);
      for (n = 0; n < RAND_PER_MOD; n++) begin
        next_cycle();
        if (draw_bits(2) == 32'd0) begin
          start_i = 1'b0;
          next_cycle();
        end
        a = pick_operand(k, m);
        b = pick_operand(k, m);
        c = pick_operand(k, m);
        d = pick_operand(k, m);
        issue_item(a, b, c, d, dot_mod_ref(k, s, a, b, c, d));
      end
    end

    next_cycle();
    start_i = 1'b0;
    while (exp_q.size() != 0) @(negedge clk_i);
    repeat (PIPE_LATENCY + 2) @(negedge clk_i);  // Catch any stray valid_o.

    $display("TESTS PASSED");
    $finish;
  end

endmodule : tb_dot_mod

/* compile.f */
+incdir+testbench
common/modred_pkg.sv
common/modred_cfg_if.sv
verilog/modred_config.sv
fold_lane/fold_stage.sv
fold_lane/fold_lane.sv
verilog/mod_combine.sv
verilog/dot_mod_top.sv
testbench/tb_dot_mod.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the dot-product testbench with Verilator.
# A $fatal in the testbench gives a non-zero exit status.
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
  --timescale 1ns/10ps \
  --top-module tb_dot_mod \
  -Mdir obj_dir \
  -f compile.f

./obj_dir/Vtb_dot_mod
